// File: Makefile
TOP = xvid_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f xvid.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f xvid.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: bus_regs.sv
// CPU register file on the 8-bit bus
// byte to word assembly, vram and XR access, interrupt mask and status
`timescale 1ns/1ps

module bus_regs (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 bus_cs_n_i,      // one access per low cycle
    input  logic                 bus_rd_nwr_i,    // 1 read, 0 write
    input  xvid_pkg::reg_num_t   bus_reg_num_i,
    input  logic                 bus_bytesel_i,   // 0 even (high) byte
    input  logic [7:0]           bus_data_i,
    output logic [7:0]           bus_data_o,
    output logic                 bus_intr_o,
    vram_if.requester            vram_o,
    input  logic                 vram_done_i,
    output logic                 xr_wr_o,
    output xvid_pkg::color_idx_t xr_addr_o,
    output xvid_pkg::word_t      xr_data_o,
    input  xvid_pkg::intr_t      intr_signal_i    // pulses from video
);
    import xvid_pkg::*;

    bus_state_t state_q;
    logic [7:0] hi_byte_q;      // even byte waiting for the odd one
    logic       commit;         // odd byte write commits a word
    logic       intr_wr;        // commit to INTR
    logic       busy;
    word_t      wr_word;
    word_t      rd_word;
    word_t      xr_addr_q;
    vram_addr_t vram_addr_q;
    word_t      vram_wdata_q;
    word_t      rd_buf_q;       // vram read buffer
    nib_mask_t  wr_mask_q;      // vram nibble write mask
    intr_t      intr_mask_q;
    intr_t      intr_status_q;  // sticky until cleared
    intr_t      intr_clear;
    intr_t      intr_signal;    // video and CPU signalled bits

    assign commit  = !bus_cs_n_i && !bus_rd_nwr_i && bus_bytesel_i;
    assign wr_word = {hi_byte_q, bus_data_i};
    assign busy    = (state_q != IDLE);
    assign intr_wr = commit && (bus_reg_num_i == REG_INTR);

    // INTR write clears low nibble, signals high nibble
    assign intr_clear  = intr_wr ? wr_word[3:0] : '0;
    assign intr_signal = intr_signal_i | (intr_wr ? wr_word[7:4] : '0);

    // request held until the arbiter answers
    assign vram_o.sel   = busy;
    assign vram_o.wr    = (state_q == WR_PEND);
    assign vram_o.mask  = wr_mask_q;
    assign vram_o.addr  = vram_addr_q;
    assign vram_o.wdata = vram_wdata_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q       <= IDLE;
            xr_wr_o       <= 1'b0;
            xr_addr_q     <= '0;
            vram_addr_q   <= '0;
            wr_mask_q     <= '0;
            intr_mask_q   <= '0;
            intr_status_q <= '0;
            bus_intr_o    <= 1'b0;
        end else begin
            xr_wr_o       <= 1'b0;      // single cycle strobe
            bus_intr_o    <= |(intr_signal & intr_mask_q & ~intr_status_q);
            intr_status_q <= (intr_status_q | intr_signal) & ~intr_clear;
            if (commit) begin
                case (bus_reg_num_i)
                    REG_XR_ADDR: xr_addr_q <= wr_word;
                    REG_XR_DATA: begin
                        // only the colour region exists
                        xr_wr_o   <= xr_addr_q[15] && (xr_addr_q[13:12] == XR_COLOR_REGION);
                        xr_addr_q <= xr_addr_q + 1'b1;
                    end
                    REG_VRAM_ADDR: begin
                        if (!busy) begin
                            vram_addr_q <= wr_word;
                            state_q     <= RD_PEND;     // prefetch into buffer
                        end
                    end
                    REG_VRAM_DATA: begin
                        if (!busy) begin
                            state_q <= WR_PEND;
                        end
                    end
                    REG_SYS_CTRL: begin
                        intr_mask_q <= wr_word[3:0];
                        wr_mask_q   <= wr_word[11:8];
                    end
                    default: ;
                endcase
            end
            if (busy && vram_done_i) begin
                state_q <= IDLE;                        // busy falls
                if (state_q == WR_PEND) begin
                    vram_addr_q <= vram_addr_q + 1'b1;  // auto increment
                end
            end
        end
    end

    // data path registers
    always_ff @(posedge clk) begin
        if (!bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i) begin
            hi_byte_q <= bus_data_i;
        end
        if (commit && bus_reg_num_i == REG_XR_DATA) begin
            xr_addr_o <= xr_addr_q[7:0];
            xr_data_o <= wr_word;
        end
        if (commit && bus_reg_num_i == REG_VRAM_DATA && !busy) begin
            vram_wdata_q <= wr_word;
        end
        if (state_q == RD_PEND && vram_done_i) begin
            rd_buf_q <= vram_o.rdata;
        end
        if (!bus_cs_n_i && bus_rd_nwr_i) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
    end

    // register read mux
    always_comb begin
        case (bus_reg_num_i)
            REG_XR_ADDR:   rd_word = xr_addr_q;
            REG_VRAM_ADDR: rd_word = vram_addr_q;
            REG_VRAM_DATA: rd_word = rd_buf_q;
            REG_SYS_CTRL:  rd_word = {busy, 3'b000, wr_mask_q, intr_status_q, intr_mask_q};
            REG_INTR:      rd_word = {12'h000, intr_status_q};
            default:       rd_word = '0;     // XR data is write only
        endcase
    end

endmodule

// File: palette_out.sv
// 256 entry palette with XR write port
// lookup, blanking and registered RGB and sync outputs
`timescale 1ns/1ps

module palette_out (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 xr_wr_i,
    input  xvid_pkg::color_idx_t xr_addr_i,
    input  xvid_pkg::word_t      xr_data_i,
    input  xvid_pkg::color_idx_t index_i,
    input  logic                 hsync_i,
    input  logic                 vsync_i,
    input  logic                 de_i,
    output xvid_pkg::rgb4_t      red_o,
    output xvid_pkg::rgb4_t      green_o,
    output xvid_pkg::rgb4_t      blue_o,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 dv_de_o
);
    import xvid_pkg::*;

    word_t      pal [256];      // 12-bit RGB in the low bits
    word_t      lookup_q;
    logic [1:0] hs_q;
    logic [1:0] vs_q;
    logic [1:0] de_q;

    // read every cycle
    always_ff @(posedge clk) begin
        if (xr_wr_i) begin
            pal[xr_addr_i] <= xr_data_i;
        end
        lookup_q <= pal[index_i];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
            hs_q    <= '0;
            vs_q    <= '0;
            de_q    <= '0;
        end else begin
            hs_q    <= {hs_q[0], hsync_i};
            vs_q    <= {vs_q[0], vsync_i};
            de_q    <= {de_q[0], de_i};
            red_o   <= de_q[0] ? lookup_q[11:8] : '0;   // black outside display
            green_o <= de_q[0] ? lookup_q[7:4]  : '0;
            blue_o  <= de_q[0] ? lookup_q[3:0]  : '0;
        end
    end

    assign hsync_o = hs_q[1];
    assign vsync_o = vs_q[1];
    assign dv_de_o = de_q[1];

endmodule

// File: video_gen.sv
// video timing counters, syncs and display enable
// vram fetch of two indexed pixels per word, frame and line interrupts
`timescale 1ns/1ps

module video_gen #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  logic                 clk,
    input  logic                 reset_i,
    output logic                 vid_sel_o,
    output xvid_pkg::vram_addr_t vid_addr_o,
    input  xvid_pkg::word_t      vid_data_i,    // one cycle after select
    output xvid_pkg::color_idx_t index_o,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 de_o,
    output xvid_pkg::intr_t      intr_signal_o
);
    import xvid_pkg::*;

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    logic [HW-1:0] h_cnt_q;
    logic [VW-1:0] v_cnt_q;
    logic          h_vis;
    logic          v_vis;
    logic          hs;
    logic          vs;
    logic [1:0]    hs_q;        // 2 cycle delays line up with index
    logic [1:0]    vs_q;
    logic [1:0]    de_q;
    logic          fetch_q;     // fetched word arrives now
    color_idx_t    lo_idx_q;    // second pixel of the word
    vram_addr_t    addr_q;

    assign h_vis = h_cnt_q < HW'(H_VISIBLE);
    assign v_vis = v_cnt_q < VW'(V_VISIBLE);
    assign hs    = (h_cnt_q >= HW'(H_VISIBLE + H_FRONT)) &&
                   (h_cnt_q < HW'(H_VISIBLE + H_FRONT + H_SYNC));
    assign vs    = (v_cnt_q >= VW'(V_VISIBLE + V_FRONT)) &&
                   (v_cnt_q < VW'(V_VISIBLE + V_FRONT + V_SYNC));

    assign vid_sel_o  = h_vis && v_vis && !h_cnt_q[0];   // even visible columns
    assign vid_addr_o = addr_q;

    // frame start at first front porch line, line start at column 0
    assign intr_signal_o = {2'b00, h_cnt_q == '0,
                            (h_cnt_q == '0) && (v_cnt_q == VW'(V_VISIBLE))};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt_q <= HW'(H_TOTAL - 1);     // last blank cycle of a frame
            v_cnt_q <= VW'(V_TOTAL - 1);
            addr_q  <= '0;
            fetch_q <= 1'b0;
            hs_q    <= '0;
            vs_q    <= '0;
            de_q    <= '0;
        end else begin
            if (h_cnt_q == HW'(H_TOTAL - 1)) begin
                h_cnt_q <= '0;
                v_cnt_q <= (v_cnt_q == VW'(V_TOTAL - 1)) ? '0 : v_cnt_q + 1'b1;
            end else begin
                h_cnt_q <= h_cnt_q + 1'b1;
            end
            if (!v_vis) begin
                addr_q <= '0;               // restart each frame
            end else if (vid_sel_o) begin
                addr_q <= addr_q + 1'b1;
            end
            fetch_q <= vid_sel_o;
            hs_q    <= {hs_q[0], hs};
            vs_q    <= {vs_q[0], vs};
            de_q    <= {de_q[0], h_vis && v_vis};
        end
    end

    // unpack high byte then low byte
    always_ff @(posedge clk) begin
        if (fetch_q) begin
            index_o  <= vid_data_i[15:8];
            lo_idx_q <= vid_data_i[7:0];
        end else begin
            index_o <= lo_idx_q;
        end
    end

    assign hsync_o = hs_q[1];
    assign vsync_o = vs_q[1];
    assign de_o    = de_q[1];

endmodule

// File: vram.sv
// 64K word video memory
// nibble masked writes and a registered read on every selected cycle
`timescale 1ns/1ps

module vram (
    input  logic   clk,
    vram_if.memory mem_i
);
    import xvid_pkg::*;

    word_t mem [65536];     // one word per address

    always_ff @(posedge clk) begin
        if (mem_i.sel) begin
            if (mem_i.wr) begin
                for (int n = 0; n < 4; n++) begin
                    if (mem_i.mask[n]) begin
                        mem[mem_i.addr][n*4 +: 4] <= mem_i.wdata[n*4 +: 4];
                    end
                end
            end
            mem_i.rdata <= mem[mem_i.addr];     // old word on a write cycle
        end
    end

endmodule

// File: vram_arbiter.sv
// video memory arbiter, video fetch has priority
// CPU gets the free slots, read data routed back per requester
`timescale 1ns/1ps

module vram_arbiter (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 vid_sel_i,     // video fetch this cycle
    input  xvid_pkg::vram_addr_t vid_addr_i,
    output xvid_pkg::word_t      vid_data_o,    // valid the cycle after select
    vram_if.memory               cpu_i,         // held CPU request
    output logic                 cpu_done_o,    // one cycle, read data valid
    vram_if.requester            mem_o          // merged memory port
);
    import xvid_pkg::*;

    logic  cpu_grant;       // CPU owns the memory this cycle
    logic  vid_gnt_q;       // video was granted last cycle
    logic  cpu_gnt_q;       // CPU was granted last cycle
    logic  cpu_rd_q;        // that CPU grant was a read
    word_t vid_hold_q;      // last video read
    word_t cpu_hold_q;      // last CPU read

    // no regrant while the CPU finishes its done cycle
    assign cpu_grant = cpu_i.sel && !vid_sel_i && !cpu_gnt_q;

    assign mem_o.sel   = vid_sel_i || cpu_grant;
    assign mem_o.wr    = cpu_grant && cpu_i.wr;     // video only reads
    assign mem_o.mask  = cpu_i.mask;
    assign mem_o.addr  = vid_sel_i ? vid_addr_i : cpu_i.addr;
    assign mem_o.wdata = cpu_i.wdata;

    // who owns the read data arriving next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vid_gnt_q <= 1'b0;
            cpu_gnt_q <= 1'b0;
            cpu_rd_q  <= 1'b0;
        end else begin
            vid_gnt_q <= vid_sel_i;
            cpu_gnt_q <= cpu_grant;
            cpu_rd_q  <= cpu_grant && !cpu_i.wr;
        end
    end

    // capture registers
    always_ff @(posedge clk) begin
        if (vid_gnt_q) begin
            vid_hold_q <= mem_o.rdata;
        end
        if (cpu_rd_q) begin
            cpu_hold_q <= mem_o.rdata;
        end
    end

    assign vid_data_o  = vid_gnt_q ? mem_o.rdata : vid_hold_q;
    assign cpu_i.rdata = cpu_rd_q ? mem_o.rdata : cpu_hold_q;
    assign cpu_done_o  = cpu_gnt_q;

endmodule

// File: vram_if.sv
// one video memory access port
// requester drives the access, memory returns read data
`timescale 1ns/1ps

interface vram_if;
    import xvid_pkg::*;

    logic       sel;      // access request or select
    logic       wr;       // write when set
    nib_mask_t  mask;     // nibble write enables
    vram_addr_t addr;
    word_t      wdata;
    word_t      rdata;    // read word

    modport requester (
        output sel, wr, mask, addr, wdata,
        input  rdata
    );

    modport memory (
        input  sel, wr, mask, addr, wdata,
        output rdata
    );

endinterface

// File: xvid.f
xvid_pkg.sv
vram_if.sv
vram.sv
vram_arbiter.sv
bus_regs.sv
video_gen.sv
palette_out.sv
xvid_main.sv
xvid_assert.sv
xvid_tb.sv

// File: xvid_assert.sv
// concurrent checks on the bus interrupt pulse and vram arbitration
// bound into bus_regs and vram_arbiter, unused checks tied off
`timescale 1ns/1ps

module xvid_assert (
    input logic                 clk,
    input logic                 reset_i,
    input logic                 intr_i,         // bus interrupt pulse
    input logic                 done_i,         // done seen by the CPU requester
    input logic                 pend_i,         // CPU request outstanding
    input logic                 vid_sel_i,      // video fetch this cycle
    input xvid_pkg::vram_addr_t vid_addr_i,
    input logic                 mem_wr_i,       // merged port write
    input xvid_pkg::vram_addr_t mem_addr_i      // merged port address
);

    // interrupt never held past one cycle
    a_intr_pulse: assert property (@(posedge clk) disable iff (reset_i)
        intr_i |=> !intr_i)
        else $error("bus_intr_o held longer than one cycle");

    // video always wins the slot, memory sees the video read
    a_no_overlap: assert property (@(posedge clk) disable iff (reset_i)
        vid_sel_i |-> !mem_wr_i && (mem_addr_i == vid_addr_i))
        else $error("CPU granted in a video fetch cycle");

    a_done_pending: assert property (@(posedge clk) disable iff (reset_i)
        done_i |-> pend_i)
        else $error("vram done without a pending CPU request");

endmodule

bind bus_regs xvid_assert i_bus_assert (
    .clk         (clk),
    .reset_i     (reset_i),
    .intr_i      (bus_intr_o),
    .done_i      (vram_done_i),
    .pend_i      (busy),
    .vid_sel_i   (1'b0),
    .vid_addr_i  ('0),
    .mem_wr_i    (1'b0),
    .mem_addr_i  ('0)
);

bind vram_arbiter xvid_assert i_arb_assert (
    .clk         (clk),
    .reset_i     (reset_i),
    .intr_i      (1'b0),
    .done_i      (1'b0),
    .pend_i      (1'b0),
    .vid_sel_i   (vid_sel_i),
    .vid_addr_i  (vid_addr_i),
    .mem_wr_i    (mem_o.wr),
    .mem_addr_i  (mem_o.addr)
);

// File: xvid_main.sv
// xvid top level
// register bus, vram with arbiter, video generator and palette output
`timescale 1ns/1ps

module xvid_main #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               bus_cs_n_i,
    input  logic               bus_rd_nwr_i,
    input  xvid_pkg::reg_num_t bus_reg_num_i,
    input  logic               bus_bytesel_i,
    input  logic [7:0]         bus_data_i,
    output logic [7:0]         bus_data_o,
    output logic               bus_intr_o,
    output xvid_pkg::rgb4_t    red_o,
    output xvid_pkg::rgb4_t    green_o,
    output xvid_pkg::rgb4_t    blue_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o
);
    import xvid_pkg::*;

    logic       vid_sel;
    vram_addr_t vid_addr;
    word_t      vid_data;
    logic       cpu_done;
    logic       xr_wr;
    color_idx_t xr_addr;
    word_t      xr_data;
    intr_t      intr_signal;
    color_idx_t index;          // pixel index from video_gen
    logic       hsync;
    logic       vsync;
    logic       de;

    vram_if cpu_vif ();         // bus_regs to arbiter
    vram_if mem_vif ();         // arbiter to vram

    bus_regs i_bus_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .bus_intr_o    (bus_intr_o),
        .vram_o        (cpu_vif.requester),
        .vram_done_i   (cpu_done),
        .xr_wr_o       (xr_wr),
        .xr_addr_o     (xr_addr),
        .xr_data_o     (xr_data),
        .intr_signal_i (intr_signal)
    );

    vram_arbiter i_vram_arbiter (
        .clk        (clk),
        .reset_i    (reset_i),
        .vid_sel_i  (vid_sel),
        .vid_addr_i (vid_addr),
        .vid_data_o (vid_data),
        .cpu_i      (cpu_vif.memory),
        .cpu_done_o (cpu_done),
        .mem_o      (mem_vif.requester)
    );

    vram i_vram (
        .clk   (clk),
        .mem_i (mem_vif.memory)
    );

    video_gen #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) i_video_gen (
        .clk           (clk),
        .reset_i       (reset_i),
        .vid_sel_o     (vid_sel),
        .vid_addr_o    (vid_addr),
        .vid_data_i    (vid_data),
        .index_o       (index),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .de_o          (de),
        .intr_signal_o (intr_signal)
    );

    palette_out i_palette_out (
        .clk       (clk),
        .reset_i   (reset_i),
        .xr_wr_i   (xr_wr),
        .xr_addr_i (xr_addr),
        .xr_data_i (xr_data),
        .index_i   (index),
        .hsync_i   (hsync),
        .vsync_i   (vsync),
        .de_i      (de),
        .red_o     (red_o),
        .green_o   (green_o),
        .blue_o    (blue_o),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o),
        .dv_de_o   (dv_de_o)
    );

endmodule

// File: xvid_pkg.sv
// shared word, address, index and colour typedefs
// bus register numbers and the XR palette region code
// CPU memory access sequencer states
package xvid_pkg;

    typedef logic [15:0] word_t;        // vram, palette or XR data word
    typedef logic [15:0] vram_addr_t;   // vram word address
    typedef logic [3:0]  nib_mask_t;    // one write enable per nibble
    typedef logic [7:0]  color_idx_t;   // palette index, high byte of a word first
    typedef logic [3:0]  rgb4_t;        // one colour channel
    typedef logic [3:0]  intr_t;        // frame start in bit 0, line start in bit 1
    typedef logic [3:0]  reg_num_t;     // bus register number

    // bus register map
    localparam reg_num_t REG_XR_ADDR   = 4'h0;
    localparam reg_num_t REG_XR_DATA   = 4'h1;
    localparam reg_num_t REG_VRAM_ADDR = 4'h2;
    localparam reg_num_t REG_VRAM_DATA = 4'h3;
    localparam reg_num_t REG_SYS_CTRL  = 4'h4;
    localparam reg_num_t REG_INTR      = 4'h5;

    // palette lives at XR addr[13:12] with addr[15] set
    localparam logic [1:0] XR_COLOR_REGION = 2'b00;

    typedef enum logic [1:0] {
        IDLE,       // no vram access held
        WR_PEND,    // write waiting for done
        RD_PEND     // prefetch read waiting for done
    } bus_state_t;

endpackage

// File: xvid_tb.sv
// testbench for xvid_main with a small video mode
// random vram, palette and interrupt tests against a reference model
// pixel stream, frame timing and blanking monitor, watchdog
`timescale 1ns/1ps

module xvid_tb;
    import xvid_pkg::*;

    localparam int H_VISIBLE   = 16;
    localparam int H_FRONT     = 2;
    localparam int H_SYNC      = 4;
    localparam int H_BACK      = 2;
    localparam int V_VISIBLE   = 4;
    localparam int V_FRONT     = 1;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 1;
    localparam int V_TOTAL     = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME       = (H_VISIBLE + H_FRONT + H_SYNC + H_BACK) * V_TOTAL;
    localparam int FRAME_WORDS = H_VISIBLE * V_VISIBLE / 2;    // two pixels per word
    localparam int N_VRAM      = 24;
    localparam int CLK_PERIOD  = 10;
    localparam int TIMEOUT_CYCLES = N_VRAM * 80 + 256 * 4 + FRAME_WORDS * 20 + 16 * FRAME + 500;
    localparam logic [31:0] SEED = 32'haa38_5784;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       cs_n;
    logic       rd_nwr;
    reg_num_t   reg_num;
    logic       bytesel;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic       intr;
    rgb4_t      red;
    rgb4_t      green;
    rgb4_t      blue;
    logic       hsync;
    logic       vsync;
    logic       dv_de;

    // reference model
    word_t      vmem_m [vram_addr_t];
    word_t      pal_m [256];
    logic       check_en = 1'b0;   // compare pixels from the next frame on
    logic       armed = 1'b0;
    logic       run_ended = 1'b0;
    int         pix_cnt = 0;
    int         frames_checked = 0;
    int         frames_seen = 0;
    int         intr_cnt = 0;
    int         hs_cnt = 0;
    int         de_lines = 0;
    int         de_run = 0;
    logic       hs_q = 1'b0;
    logic       vs_q = 1'b0;
    logic       de_q = 1'b0;
    word_t      pix_word;
    color_idx_t pix_idx;

    always #(CLK_PERIOD / 2) clk = ~clk;

    xvid_main #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) i_xvid_main (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (cs_n),
        .bus_rd_nwr_i  (rd_nwr),
        .bus_reg_num_i (reg_num),
        .bus_bytesel_i (bytesel),
        .bus_data_i    (wdata),
        .bus_data_o    (rdata),
        .bus_intr_o    (intr),
        .red_o         (red),
        .green_o       (green),
        .blue_o        (blue),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .dv_de_o       (dv_de)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            run_ended = 1'b1;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // even byte latches, odd byte commits
    task automatic bus_write(input reg_num_t r, input word_t w);
        cs_n    = 1'b0;
        rd_nwr  = 1'b0;
        reg_num = r;
        bytesel = 1'b0;
        wdata   = w[15:8];
        @(posedge clk);
        #1;
        bytesel = 1'b1;
        wdata   = w[7:0];
        @(posedge clk);
        #1;
        cs_n = 1'b1;
    endtask

    task automatic bus_read(input reg_num_t r, output word_t w);
        cs_n    = 1'b0;
        rd_nwr  = 1'b1;
        reg_num = r;
        bytesel = 1'b0;
        @(posedge clk);
        #1;
        w[15:8] = rdata;           // high byte from the previous access
        bytesel = 1'b1;
        @(posedge clk);
        #1;
        cs_n    = 1'b1;
        w[7:0]  = rdata;
    endtask

    // poll SYS_CTRL bit 15 until the vram access ends
    task automatic wait_idle();
        word_t st;
        int    n;
        n  = 0;
        st = 16'h8000;
        while (st[15] && n < 16) begin
            bus_read(REG_SYS_CTRL, st);
            n++;
        end
        if (st[15]) begin
            run_ended = 1'b1;
            $display("vram access never finished, busy still set at %0t", $time);
            $display("TEST FAIL");
            $fatal(1, "busy stuck");
        end
    endtask

    task automatic set_ctrl(input nib_mask_t wr_mask, input intr_t intr_mask);
        bus_write(REG_SYS_CTRL, {4'h0, wr_mask, 4'h0, intr_mask});
    endtask

    task automatic vram_set_addr(input vram_addr_t a);
        bus_write(REG_VRAM_ADDR, a);    // also prefetches into the buffer
        wait_idle();
    endtask

    task automatic vram_store(input word_t w);
        bus_write(REG_VRAM_DATA, w);
        wait_idle();
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_frames(input int n);
        int start;
        start = frames_checked;
        wait (frames_checked >= start + n);
        @(posedge clk);
        #1;
    endtask

    function automatic word_t merge_nibbles(word_t old_w, word_t new_w, nib_mask_t m);
        word_t r;
        r = old_w;
        for (int n = 0; n < 4; n++) begin
            if (m[n]) begin
                r[n*4 +: 4] = new_w[n*4 +: 4];
            end
        end
        return r;
    endfunction

    // pixel stream, blanking, frame shape and interrupt count
    always @(negedge clk) begin
        if (!reset_i) begin
            if (intr) intr_cnt++;
            if (!dv_de) check("rgb outside display", {red, green, blue}, 0);
            if (dv_de && armed) begin
                pix_word = vmem_m[vram_addr_t'(pix_cnt / 2)];
                pix_idx  = pix_cnt[0] ? pix_word[7:0] : pix_word[15:8];   // high byte first
                check("rgb", {red, green, blue}, pal_m[pix_idx][11:0]);
                pix_cnt++;
            end
            if (hsync && !hs_q) hs_cnt++;
            if (dv_de) de_run++;
            if (!dv_de && de_q) begin
                check("dv_de_o cycles per line", de_run, H_VISIBLE);
                de_lines++;
                de_run = 0;
            end
            if (vsync && !vs_q) begin                   // frame boundary
                if (frames_seen > 0) begin
                    check("hsync pulses per frame", hs_cnt, V_TOTAL);
                    check("dv_de_o lines per frame", de_lines, V_VISIBLE);
                end
                if (armed) begin
                    check("pixels per frame", pix_cnt, 2 * FRAME_WORDS);
                    frames_checked++;
                end
                frames_seen++;
                hs_cnt   = 0;
                de_lines = 0;
                pix_cnt  = 0;
                armed    = check_en;
            end
            hs_q = hsync;
            vs_q = vsync;
            de_q = dv_de;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        run_ended = 1'b1;
        $display("watchdog expired after %0d cycles, test did not complete", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    // run stopped before the last test
    final begin
        if (!run_ended) $display("TEST FAIL");
    end

    initial begin
        word_t      rd;
        word_t      d0;
        word_t      d1;
        vram_addr_t a;
        nib_mask_t  m;
        int         c0;
        reset_i = 1'b1;
        cs_n    = 1'b1;
        rd_nwr  = 1'b1;
        reg_num = REG_XR_ADDR;
        bytesel = 1'b0;
        wdata   = 8'h00;
        rd      = word_t'($urandom(SEED));
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // reset state, read before the first line start sets status
        check("bus_intr_o after reset", intr, 0);
        check("rgb after reset", {red, green, blue}, 0);
        bus_read(REG_SYS_CTRL, rd);
        check("sys_ctrl after reset", rd, 0);

        // masked vram writes over a known full word
        for (int i = 0; i < N_VRAM; i++) begin
            a  = vram_addr_t'($urandom);
            d0 = word_t'($urandom);
            d1 = word_t'($urandom);
            m  = nib_mask_t'($urandom);
            set_ctrl(4'hF, 4'h0);
            vram_set_addr(a);
            vram_store(d0);
            vmem_m[a] = d0;
            bus_read(REG_VRAM_ADDR, rd);
            check("vram_addr increment", rd, word_t'(a + 1));
            set_ctrl(m, 4'h0);
            vram_set_addr(a);
            vram_store(d1);
            vmem_m[a] = merge_nibbles(vmem_m[a], d1, m);
            vram_set_addr(a);
            bus_read(REG_VRAM_DATA, rd);
            check("vram_data", rd, vmem_m[a]);
        end

        // full palette, then one frame of indices
        set_ctrl(4'hF, 4'h0);
        bus_write(REG_XR_ADDR, 16'h8000);
        for (int i = 0; i < 256; i++) begin
            pal_m[i] = word_t'($urandom);
            bus_write(REG_XR_DATA, pal_m[i]);
        end
        vram_set_addr('0);
        for (int i = 0; i < FRAME_WORDS; i++) begin
            vmem_m[vram_addr_t'(i)] = word_t'($urandom);
            vram_store(vmem_m[vram_addr_t'(i)]);
        end
        check_en = 1'b1;
        wait_frames(2);

        // frame interrupt, one pulse until cleared
        set_ctrl(4'hF, 4'h1);
        bus_write(REG_INTR, 16'h000F);
        c0 = intr_cnt;
        wait_cycles(2 * FRAME);
        check("frame intr pulses", intr_cnt - c0, 1);
        bus_read(REG_INTR, rd);
        check("frame status bit", rd[0], 1);
        bus_write(REG_INTR, 16'h0001);
        wait_cycles(FRAME + 4);
        check("frame intr after clear", intr_cnt - c0, 2);

        // CPU signalled bits, bit 3 masked off
        set_ctrl(4'hF, 4'h4);
        bus_write(REG_INTR, 16'h000F);
        c0 = intr_cnt;
        bus_write(REG_INTR, 16'h0040);
        check("bus_intr_o after cpu signal", intr, 1);
        wait_cycles(4);
        bus_write(REG_INTR, 16'h0040);  // already pending
        wait_cycles(4);
        bus_write(REG_INTR, 16'h0080);
        wait_cycles(4);
        check("cpu intr pulses", intr_cnt - c0, 1);
        bus_read(REG_INTR, rd);
        check("cpu status bits", rd[3:2], 2'b11);
        bus_write(REG_INTR, 16'h0004);
        bus_write(REG_INTR, 16'h0040);
        wait_cycles(4);
        check("cpu intr after clear", intr_cnt - c0, 2);

        // XR writes outside the colour region, aimed at the first pixel's entry
        bus_write(REG_XR_ADDR, 16'h9000 | 16'(vmem_m[vram_addr_t'(0)][15:8]));
        for (int i = 0; i < 4; i++) begin
            bus_write(REG_XR_DATA, word_t'($urandom));
        end
        bus_write(REG_XR_ADDR, 16'h0000 | 16'(vmem_m[vram_addr_t'(0)][15:8]));
        for (int i = 0; i < 4; i++) begin
            bus_write(REG_XR_DATA, word_t'($urandom));
        end
        wait_frames(2);

        run_ended = 1'b1;
        $display("TEST PASS");
        $finish;
    end

endmodule
